/* include/icache_macros.svh */
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// byte address width.
`define ADDR_W 12

// cache geometry with 16-byte lines.
`define SETS 16
`define INDEX_W 4
`define WAYS 4
`define TAG_W 4

// backing store depth in lines.
`define MEM_LINES 256

// cycles from mem_req to mem_ack.
`define MEM_LAT 3

`endif

/* logic/icache_pkg.sv */
`include "icache_macros.svh"

package icache_pkg;

	// byte address into the line memory.
	typedef logic [`ADDR_W-1:0] addr_t;

	// one instruction or data word.
	typedef logic [31:0] word_t;

	// four words per line with word 0 in the low bits.
	typedef logic [127:0] line_t;

	// one bit per way.
	typedef logic [`WAYS-1:0] way_mask_t;

	// miss handling states.
	typedef enum logic [1:0] {
		ST_IDLE,	// waiting for a fetch.
		ST_REQ,		// refill request goes out.
		ST_WAIT		// waiting for the refill line.
	} icache_state_e;

	typedef enum logic {
		MEM_READ,
		MEM_WRITE
	} mem_op_e;

	// who holds the line memory right now.
	typedef enum logic [1:0] {
		OWN_NONE,
		OWN_ICACHE,
		OWN_DPORT
	} arb_owner_e;

endpackage

/* logic/icache_tag_array.sv */
`timescale 1ns/10ps
`include "icache_macros.svh"

module icache_tag_array (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  inv,
	input  icache_pkg::addr_t     lookup_addr,
	input  logic                  fill,
	input  icache_pkg::way_mask_t fill_way,
	output icache_pkg::way_mask_t way_hit,
	output icache_pkg::way_mask_t victim
);

	localparam int OFF_W = `ADDR_W - `TAG_W - `INDEX_W;

	logic [`TAG_W-1:0]   tags [`WAYS][`SETS];
	logic [`SETS-1:0]    valid [`WAYS];
	logic [`INDEX_W-1:0] index;
	logic [`TAG_W-1:0]   tag;

	assign index = lookup_addr[OFF_W +: `INDEX_W];
	assign tag   = lookup_addr[OFF_W + `INDEX_W +: `TAG_W];

	// all ways compared in parallel.
	always_comb begin
		for (int w = 0; w < `WAYS; w++) begin
			way_hit[w] = valid[w][index] && (tags[w][index] == tag);
		end
	end

	// tag storage is written only on a refill.
	always_ff @(posedge clk) begin
		for (int w = 0; w < `WAYS; w++) begin
			if (fill && fill_way[w]) begin
				tags[w][index] <= tag;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < `WAYS; w++) begin
				valid[w] <= '0;
			end
			victim <= icache_pkg::way_mask_t'(1);	// way 0 first.
		end else if (inv) begin
			// like fence.i, every line goes stale at once.
			for (int w = 0; w < `WAYS; w++) begin
				valid[w] <= '0;
			end
		end else if (fill) begin
			for (int w = 0; w < `WAYS; w++) begin
				if (fill_way[w]) begin
					valid[w][index] <= 1'b1;
				end
			end
			victim <= {victim[`WAYS-2:0], victim[`WAYS-1]};	// rotate left.
		end
	end

endmodule

/* logic/icache_data_ram.sv */
`timescale 1ns/10ps
`include "icache_macros.svh"

module icache_data_ram (
	input  logic                clk,
	input  logic                en,
	input  logic                we,
	input  logic [`INDEX_W-1:0] index,
	input  icache_pkg::line_t   wline,
	output icache_pkg::line_t   rline
);

	icache_pkg::line_t mem [`SETS];

	// single port with the read data one cycle later.
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[index] <= wline;
			end else begin
				rline <= mem[index];
			end
		end
	end

endmodule

/* logic/icache.sv */
`timescale 1ns/10ps
`include "icache_macros.svh"

module icache (
	input  logic              clk,
	input  logic              rst,
	input  logic              fetch_valid,
	input  icache_pkg::addr_t fetch_addr,
	input  logic              inv,
	input  logic              refill_done,
	input  icache_pkg::line_t refill_line,
	output logic              fetch_ready,
	output icache_pkg::word_t fetch_inst,
	output logic              refill_req,
	output icache_pkg::addr_t refill_addr
);

	localparam int OFF_W = `ADDR_W - `TAG_W - `INDEX_W;

	icache_pkg::icache_state_e state;
	icache_pkg::way_mask_t     way_hit;
	icache_pkg::way_mask_t     victim;
	icache_pkg::way_mask_t     ram_en;
	icache_pkg::way_mask_t     sel_way;
	icache_pkg::line_t         rline [`WAYS];
	icache_pkg::line_t         fill_line_q;
	icache_pkg::line_t         resp_line;
	logic                      accept;
	logic                      fill;
	logic                      from_fill;
	logic [OFF_W-3:0]          word_q;
	logic [`INDEX_W-1:0]       index;

	assign index = fetch_addr[OFF_W +: `INDEX_W];

	// a request is taken once, never in its own ready cycle.
	assign accept = (state == icache_pkg::ST_IDLE) && fetch_valid && !fetch_ready;
	assign fill   = (state == icache_pkg::ST_WAIT) && refill_done;

	// hit reads one way, refill writes the victim.
	assign ram_en = fill ? victim : (accept ? way_hit : '0);

	assign refill_req  = (state == icache_pkg::ST_REQ);
	assign refill_addr = {fetch_addr[`ADDR_W-1:OFF_W], {OFF_W{1'b0}}};	// line aligned.

	icache_tag_array u_tag_array (
		.clk        (clk),
		.rst        (rst),
		.inv        (inv),
		.lookup_addr(fetch_addr),
		.fill       (fill),
		.fill_way   (victim),
		.way_hit    (way_hit),
		.victim     (victim)
	);

	for (genvar w = 0; w < `WAYS; w++) begin : g_way
		icache_data_ram u_data_ram (
			.clk  (clk),
			.en   (ram_en[w]),
			.we   (fill),
			.index(index),
			.wline(refill_line),
			.rline(rline[w])
		);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state       <= icache_pkg::ST_IDLE;
			fetch_ready <= 1'b0;
			sel_way     <= '0;
			from_fill   <= 1'b0;
		end else begin
			fetch_ready <= 1'b0;
			case (state)
				icache_pkg::ST_IDLE: begin
					if (accept) begin
						if (|way_hit) begin
							fetch_ready <= 1'b1;
							sel_way     <= way_hit;
							from_fill   <= 1'b0;
						end else begin
							state <= icache_pkg::ST_REQ;
						end
					end
				end
				icache_pkg::ST_REQ: begin
					state <= icache_pkg::ST_WAIT;
				end
				icache_pkg::ST_WAIT: begin
					if (refill_done) begin
						fetch_ready <= 1'b1;
						from_fill   <= 1'b1;	// answer from the refill register.
						state       <= icache_pkg::ST_IDLE;
					end
				end
				default: begin
					state <= icache_pkg::ST_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			word_q <= fetch_addr[OFF_W-1:2];
		end
		if (fill) begin
			fill_line_q <= refill_line;
		end
	end

	// pick the line that answers this fetch.
	always_comb begin
		resp_line = fill_line_q;
		if (!from_fill) begin
			resp_line = '0;
			for (int w = 0; w < `WAYS; w++) begin
				if (sel_way[w]) begin
					resp_line = rline[w];
				end
			end
		end
	end

	assign fetch_inst = resp_line[32*word_q +: 32];

endmodule

/* logic/mem_arbiter.sv */
`timescale 1ns/10ps
`include "icache_macros.svh"

module mem_arbiter (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  refill_req,
	input  icache_pkg::addr_t     refill_addr,
	input  logic                  dp_req,
	input  icache_pkg::mem_op_e   dp_op,
	input  icache_pkg::addr_t     dp_addr,
	input  icache_pkg::word_t     dp_wdata,
	input  logic                  mem_ack,
	input  icache_pkg::line_t     mem_rline,
	output logic                  refill_done,
	output icache_pkg::line_t     refill_line,
	output logic                  dp_done,
	output icache_pkg::word_t     dp_rdata,
	output logic                  mem_req,
	output icache_pkg::mem_op_e   mem_op,
	output icache_pkg::addr_t     mem_addr,
	output icache_pkg::word_t     mem_wdata
);

	localparam int OFF_W = `ADDR_W - `TAG_W - `INDEX_W;

	icache_pkg::arb_owner_e owner;
	icache_pkg::addr_t      ic_addr_q;
	icache_pkg::addr_t      dp_addr_q;
	icache_pkg::mem_op_e    dp_op_q;
	icache_pkg::word_t      dp_wdata_q;
	logic                   ic_pend;
	logic                   dp_pend;
	logic                   last_dp;
	logic                   grant_ic;
	logic                   grant_dp;

	// on a tie the side served last waits.
	assign grant_ic = (owner == icache_pkg::OWN_NONE) && ic_pend && (!dp_pend || last_dp);
	assign grant_dp = (owner == icache_pkg::OWN_NONE) && dp_pend && (!ic_pend || !last_dp);

	always_ff @(posedge clk) begin
		if (rst) begin
			owner       <= icache_pkg::OWN_NONE;
			ic_pend     <= 1'b0;
			dp_pend     <= 1'b0;
			last_dp     <= 1'b0;
			mem_req     <= 1'b0;
			refill_done <= 1'b0;
			dp_done     <= 1'b0;
		end else begin
			mem_req     <= grant_ic || grant_dp;
			refill_done <= 1'b0;
			dp_done     <= 1'b0;
			if (grant_ic) begin
				ic_pend <= 1'b0;
				owner   <= icache_pkg::OWN_ICACHE;
			end else if (grant_dp) begin
				dp_pend <= 1'b0;
				owner   <= icache_pkg::OWN_DPORT;
			end
			if (mem_ack) begin
				// hand the result back and free the memory.
				refill_done <= (owner == icache_pkg::OWN_ICACHE);
				dp_done     <= (owner == icache_pkg::OWN_DPORT);
				last_dp     <= (owner == icache_pkg::OWN_DPORT);
				owner       <= icache_pkg::OWN_NONE;
			end
			if (refill_req) begin
				ic_pend <= 1'b1;
			end
			if (dp_req) begin
				dp_pend <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (refill_req) begin
			ic_addr_q <= refill_addr;
		end
		if (dp_req) begin
			dp_op_q    <= dp_op;
			dp_addr_q  <= dp_addr;
			dp_wdata_q <= dp_wdata;
		end
		if (grant_ic) begin
			mem_op    <= icache_pkg::MEM_READ;	// refills only read.
			mem_addr  <= ic_addr_q;
			mem_wdata <= '0;
		end else if (grant_dp) begin
			mem_op    <= dp_op_q;
			mem_addr  <= dp_addr_q;
			mem_wdata <= dp_wdata_q;
		end
		if (mem_ack) begin
			refill_line <= mem_rline;
			dp_rdata    <= mem_rline[32*mem_addr[OFF_W-1:2] +: 32];	// addressed word.
		end
	end

endmodule

/* logic/line_mem.sv */
`timescale 1ns/10ps
`include "icache_macros.svh"

module line_mem (
	input  logic                clk,
	input  logic                rst,
	input  logic                mem_req,
	input  icache_pkg::mem_op_e mem_op,
	input  icache_pkg::addr_t   mem_addr,
	input  icache_pkg::word_t   mem_wdata,
	output logic                mem_ack,
	output icache_pkg::line_t   mem_rline
);

	localparam int OFF_W  = `ADDR_W - `TAG_W - `INDEX_W;
	localparam int LINE_W = $clog2(`MEM_LINES);
	localparam int CNT_W  = $clog2(`MEM_LAT + 1);

	icache_pkg::line_t   mem [`MEM_LINES] = '{default: '0};
	icache_pkg::mem_op_e op_q;
	icache_pkg::addr_t   addr_q;
	icache_pkg::word_t   wdata_q;
	logic [CNT_W-1:0]    cnt;
	logic [LINE_W-1:0]   line_idx;
	logic                last;

	assign line_idx = addr_q[OFF_W +: LINE_W];
	assign last     = (cnt == CNT_W'(1));	// access happens on this edge.

	// nonzero count means an access is in flight.
	always_ff @(posedge clk) begin
		if (rst) begin
			cnt     <= '0;
			mem_ack <= 1'b0;
		end else begin
			mem_ack <= last;
			if (mem_req && cnt == '0) begin
				cnt <= CNT_W'(`MEM_LAT - 1);
			end else if (cnt != '0) begin
				cnt <= cnt - CNT_W'(1);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (mem_req) begin
			op_q    <= mem_op;
			addr_q  <= mem_addr;
			wdata_q <= mem_wdata;
		end
		if (last) begin
			mem_rline <= mem[line_idx];	// old contents even on a write.
			if (op_q == icache_pkg::MEM_WRITE) begin
				mem[line_idx][32*addr_q[OFF_W-1:2] +: 32] <= wdata_q;
			end
		end
	end

endmodule

/* logic/fetch_subsys.sv */
`timescale 1ns/10ps

module fetch_subsys (
	input  logic                clk,
	input  logic                rst,
	input  logic                fetch_valid,
	input  icache_pkg::addr_t   fetch_addr,
	input  logic                inv,
	input  logic                dp_req,
	input  icache_pkg::mem_op_e dp_op,
	input  icache_pkg::addr_t   dp_addr,
	input  icache_pkg::word_t   dp_wdata,
	output logic                fetch_ready,
	output icache_pkg::word_t   fetch_inst,
	output logic                dp_done,
	output icache_pkg::word_t   dp_rdata
);

	logic                refill_req;
	logic                refill_done;
	icache_pkg::addr_t   refill_addr;
	icache_pkg::line_t   refill_line;
	logic                mem_req;
	logic                mem_ack;
	icache_pkg::mem_op_e mem_op;
	icache_pkg::addr_t   mem_addr;
	icache_pkg::word_t   mem_wdata;
	icache_pkg::line_t   mem_rline;

	icache u_icache (
		.clk        (clk),
		.rst        (rst),
		.fetch_valid(fetch_valid),
		.fetch_addr (fetch_addr),
		.inv        (inv),
		.refill_done(refill_done),
		.refill_line(refill_line),
		.fetch_ready(fetch_ready),
		.fetch_inst (fetch_inst),
		.refill_req (refill_req),
		.refill_addr(refill_addr)
	);

	// data port goes straight into the arbiter.
	mem_arbiter u_mem_arbiter (
		.clk        (clk),
		.rst        (rst),
		.refill_req (refill_req),
		.refill_addr(refill_addr),
		.dp_req     (dp_req),
		.dp_op      (dp_op),
		.dp_addr    (dp_addr),
		.dp_wdata   (dp_wdata),
		.mem_ack    (mem_ack),
		.mem_rline  (mem_rline),
		.refill_done(refill_done),
		.refill_line(refill_line),
		.dp_done    (dp_done),
		.dp_rdata   (dp_rdata),
		.mem_req    (mem_req),
		.mem_op     (mem_op),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata)
	);

	line_mem u_line_mem (
		.clk      (clk),
		.rst      (rst),
		.mem_req  (mem_req),
		.mem_op   (mem_op),
		.mem_addr (mem_addr),
		.mem_wdata(mem_wdata),
		.mem_ack  (mem_ack),
		.mem_rline(mem_rline)
	);

endmodule

/* verif/fetch_asserts.sv */
`timescale 1ns/10ps

module fetch_asserts (
	input logic                   clk,
	input logic                   rst,
	input logic                   mem_req,
	input logic                   mem_ack,
	input icache_pkg::arb_owner_e owner,
	input icache_pkg::way_mask_t  way_hit,
	input logic                   fetch_valid,
	input logic                   fetch_ready
);

	logic busy;

	// high from mem_req until its mem_ack.
	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
		end else begin
			busy <= mem_req || (busy && !mem_ack);
		end
	end

	no_overlap: assert property (@(posedge clk) disable iff (rst)
		mem_req |-> !busy)
		else $error("mem_req raised while an access was outstanding");

	ack_owned: assert property (@(posedge clk) disable iff (rst)
		mem_ack |-> (owner != icache_pkg::OWN_NONE))
		else $error("mem_ack arrived with no arbiter owner");

	// a line lives in at most one way.
	hit_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot0(way_hit))
		else $error("way_hit has more than one way set");

	ready_after_valid: assert property (@(posedge clk) disable iff (rst)
		fetch_ready |-> $past(fetch_valid))
		else $error("fetch_ready without a fetch_valid before it");

endmodule

/* verif/fetch_tb.sv */
`timescale 1ns/10ps
`include "icache_macros.svh"

module fetch_tb;

	localparam int N_WR     = 40;
	localparam int N_FETCH  = 48;
	localparam int N_HIT    = 8;
	localparam int N_CONC   = 16;
	localparam int WAIT_MAX = 4 * (`MEM_LAT + 10);	// per access.
	localparam int N_OPS    = 2 * N_WR + 5 + 3 + N_FETCH + 2 * N_HIT + 6 + 2 * N_CONC;
	localparam int LIMIT    = N_OPS * (`MEM_LAT + 10) + 200;

	logic                clk;
	logic                rst;
	logic                fetch_valid;
	icache_pkg::addr_t   fetch_addr;
	logic                inv;
	logic                dp_req;
	icache_pkg::mem_op_e dp_op;
	icache_pkg::addr_t   dp_addr;
	icache_pkg::word_t   dp_wdata;
	logic                fetch_ready;
	icache_pkg::word_t   fetch_inst;
	logic                dp_done;
	icache_pkg::word_t   dp_rdata;

	icache_pkg::line_t   model [`MEM_LINES];	// expected memory contents.
	icache_pkg::addr_t   wr_addr [N_WR];
	icache_pkg::addr_t   set_addr [5];
	icache_pkg::addr_t   cf_addr [N_CONC];
	icache_pkg::addr_t   cd_addr [N_CONC];
	icache_pkg::word_t   cd_data [N_CONC];
	icache_pkg::mem_op_e cd_op [N_CONC];
	integer              seed;
	int                  mismatch_count;
	int                  other_count;
	bit                  concurrent;	// both ports busy at once.

	fetch_subsys u_fetch_subsys (
		.clk        (clk),
		.rst        (rst),
		.fetch_valid(fetch_valid),
		.fetch_addr (fetch_addr),
		.inv        (inv),
		.dp_req     (dp_req),
		.dp_op      (dp_op),
		.dp_addr    (dp_addr),
		.dp_wdata   (dp_wdata),
		.fetch_ready(fetch_ready),
		.fetch_inst (fetch_inst),
		.dp_done    (dp_done),
		.dp_rdata   (dp_rdata)
	);

	bind fetch_subsys fetch_asserts u_fetch_asserts (
		.clk        (clk),
		.rst        (rst),
		.mem_req    (mem_req),
		.mem_ack    (mem_ack),
		.owner      (u_mem_arbiter.owner),
		.way_hit    (u_icache.way_hit),
		.fetch_valid(fetch_valid),
		.fetch_ready(fetch_ready)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic icache_pkg::word_t rand_word();
		return $random(seed);
	endfunction

	// tag and index pick the line, bits 3:2 the word.
	function automatic icache_pkg::word_t model_word(input icache_pkg::addr_t a);
		return model[a[11:4]][32*a[3:2] +: 32];
	endfunction

	task automatic check_word(input string name, input icache_pkg::word_t got,
			input icache_pkg::word_t exp);
		if (got !== exp) begin
			mismatch_count++;
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			mismatch_count++;
			$display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic pulse_inv();
		@(negedge clk);
		inv = 1'b1;
		@(negedge clk);
		inv = 1'b0;
	endtask

	task automatic fetch_compare(input icache_pkg::addr_t a, input bit expect_hit);
		int cycles;
		bit done;
		cycles = 0;
		done   = 1'b0;
		@(negedge clk);
		check_flag("fetch_ready", fetch_ready, 1'b0);
		fetch_valid = 1'b1;
		fetch_addr  = a;
		while (!done && cycles < WAIT_MAX) begin
			@(negedge clk);
			cycles++;
			if (expect_hit && cycles == 1) begin
				check_flag("fetch_ready", fetch_ready, 1'b1);	// hit answers next cycle.
			end
			if (!concurrent) begin
				check_flag("dp_done", dp_done, 1'b0);
			end
			done = fetch_ready;
		end
		fetch_valid = 1'b0;
		if (done) begin
			check_word("fetch_inst", fetch_inst, model_word(a));
		end else begin
			other_count++;
			$display("fetch of %h got no fetch_ready within %0d cycles", a, WAIT_MAX);
		end
	endtask

	task automatic access_dport(input icache_pkg::mem_op_e op, input icache_pkg::addr_t a,
			input icache_pkg::word_t d);
		icache_pkg::word_t expected;
		int                cycles;
		bit                done;
		expected = model_word(a);	// old word even on a write.
		cycles   = 0;
		done     = 1'b0;
		@(negedge clk);
		check_flag("dp_done", dp_done, 1'b0);
		dp_req   = 1'b1;
		dp_op    = op;
		dp_addr  = a;
		dp_wdata = d;
		while (!done && cycles < WAIT_MAX) begin
			@(negedge clk);
			dp_req = 1'b0;
			cycles++;
			if (!concurrent) begin
				check_flag("fetch_ready", fetch_ready, 1'b0);
			end
			done = dp_done;
		end
		if (!done) begin
			other_count++;
			$display("data port access to %h got no dp_done within %0d cycles", a, WAIT_MAX);
		end else begin
			if (cycles < `MEM_LAT + 1) begin
				other_count++;
				$display("dp_done came %0d cycles after dp_req, faster than the memory", cycles);
			end
			check_word("dp_rdata", dp_rdata, expected);
			if (op == icache_pkg::MEM_WRITE) begin
				model[a[11:4]][32*a[3:2] +: 32] = d;
			end
		end
	endtask

	initial begin
		repeat (LIMIT) @(posedge clk);
		$display("watchdog expired after %0d cycles", LIMIT);
		$display("error count: %0d mismatches, %0d other", mismatch_count, other_count);
		$display("tests failed");
		$finish;
	end

	initial begin
		icache_pkg::word_t rnd;
		icache_pkg::addr_t a;
		logic [3:0]        tag;
		logic [3:0]        set_idx;
		logic [1:0]        word_idx;
		seed           = 88;
		mismatch_count = 0;
		other_count    = 0;
		concurrent     = 1'b0;
		for (int i = 0; i < `MEM_LINES; i++) begin
			model[i] = '0;
		end
		rst         = 1'b1;
		fetch_valid = 1'b0;
		fetch_addr  = '0;
		inv         = 1'b0;
		dp_req      = 1'b0;
		dp_op       = icache_pkg::MEM_READ;
		dp_addr     = '0;
		dp_wdata    = '0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// writes return the old word, reads return the last one written.
		for (int i = 0; i < N_WR; i++) begin
			rnd        = rand_word();
			wr_addr[i] = (i < N_WR / 2) ? {rnd[11:2], 2'b00} : wr_addr[i - N_WR / 2];
			access_dport(icache_pkg::MEM_WRITE, wr_addr[i], rand_word());
		end
		for (int i = 0; i < N_WR; i++) begin
			access_dport(icache_pkg::MEM_READ, wr_addr[i], '0);
		end

		// five tags that all land in one set.
		rnd      = rand_word();
		tag      = rnd[3:0];
		set_idx  = rnd[7:4];
		word_idx = rnd[9:8];
		for (int i = 0; i < 5; i++) begin
			set_addr[i] = {tag, set_idx, word_idx, 2'b00};
			access_dport(icache_pkg::MEM_WRITE, set_addr[i], rand_word());
			tag = tag + 4'd1;
		end
		pulse_inv();

		for (int i = 0; i < N_FETCH; i++) begin
			rnd = rand_word();
			a   = rnd[31] ? wr_addr[int'(rnd[5:0]) % N_WR] : {rnd[11:2], 2'b00};
			fetch_compare(a, 1'b0);
		end

		// the same address twice so that the second one hits.
		for (int i = 0; i < N_HIT; i++) begin
			rnd = rand_word();
			a   = wr_addr[int'(rnd[5:0]) % N_WR];
			fetch_compare(a, 1'b0);
			fetch_compare(a, 1'b1);
		end

		for (int i = 0; i < 5; i++) begin
			fetch_compare(set_addr[i], 1'b0);
		end
		fetch_compare(set_addr[0], 1'b0);

		// fetches in the lower half, data port in the upper half.
		for (int i = 0; i < N_CONC; i++) begin
			rnd        = rand_word();
			cf_addr[i] = {1'b0, rnd[10:2], 2'b00};
			cd_addr[i] = {1'b1, rnd[21:13], 2'b00};
			cd_op[i]   = rnd[31] ? icache_pkg::MEM_WRITE : icache_pkg::MEM_READ;
			cd_data[i] = rand_word();
		end
		pulse_inv();
		concurrent = 1'b1;
		fork
			begin
				for (int i = 0; i < N_CONC; i++) begin
					fetch_compare(cf_addr[i], 1'b0);
				end
			end
			begin
				for (int i = 0; i < N_CONC; i++) begin
					access_dport(cd_op[i], cd_addr[i], cd_data[i]);
				end
			end
		join
		concurrent = 1'b0;

		@(negedge clk);
		$display("error count: %0d mismatches, %0d other", mismatch_count, other_count);
		if (mismatch_count == 0 && other_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

/* project.f */
+incdir+include
logic/icache_pkg.sv
logic/icache_tag_array.sv
logic/icache_data_ram.sv
logic/icache.sv
logic/mem_arbiter.sv
logic/line_mem.sv
logic/fetch_subsys.sv
verif/fetch_asserts.sv
verif/fetch_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the fetch subsystem testbench with Verilator and runs it once.

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
	echo "verilator not found in PATH"
	exit 1
fi

verilator --binary --timing --assert --top-module fetch_tb -f project.f -o fetch_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/fetch_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "all tests passed"; then
	exit 0
fi
echo "simulation did not report a pass"
exit 1
